// ==== common/linemult_defs.svh ====
////////////////////////////////////////////////////////////////////////////
// widths, buffer size and active-window limits of the line doubler
// included by the packages and by every block that needs a limit
////////////////////////////////////////////////////////////////////////////

`ifndef LINEMULT_DEFS_SVH
`define LINEMULT_DEFS_SVH

// bits per color channel
`define COLOR_W 7

// line buffer pages and pixel counter width
`define BUF_PAGES 4
`define HCNT_W 10

// sample count at which a line is treated as overflowed
`define LINE_MAX 1000

// active window, first sample inside and first sample past it
`define HSTART_NTSC 120
`define HSTOP_NTSC 600
`define HSTART_PAL 128
`define HSTOP_PAL 640

// output hsync pulse in output pixels
`define HS_WIDTH 64

// page whose completion starts the reader
`define START_PAGE 2

`endif

// ==== common/video_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// pixel and sync types of the RGB video stream
////////////////////////////////////////////////////////////////////////////

`include "linemult_defs.svh"

package video_pkg;

  // one RGB pixel, red in the upper bits
  typedef struct packed {
    logic [`COLOR_W-1:0] r;
    logic [`COLOR_W-1:0] g;
    logic [`COLOR_W-1:0] b;
  } pixel_t;

  // both syncs are active low
  typedef struct packed {
    logic nvs;
    logic nhs;
  } sync_t;

  // one stream word, syncs on top of the pixel
  typedef struct packed {
    sync_t  sync;
    pixel_t pix;
  } vid_t;

endpackage

// ==== common/linemult_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// configuration, counter and page types shared by the line doubler blocks
////////////////////////////////////////////////////////////////////////////

`include "linemult_defs.svh"

package linemult_pkg;

  // static configuration, only changed between frames
  typedef struct packed {
    logic       lx2_en;
    logic       pal_mode;
    logic       sl_en;
    // scanline strength, 0 leaves the line untouched
    logic [3:0] sl_str;
  } cfg_t;

  // pixel count within a line, also used as buffer address
  typedef logic [`HCNT_W-1:0] hcnt_t;

  typedef logic [$clog2(`BUF_PAGES)-1:0] page_t;

  // what the writer records per stored line
  typedef struct packed {
    hcnt_t width;
    logic  vs_low;
  } line_info_t;

endpackage

// ==== linebuf/line_writer.sv ====
////////////////////////////////////////////////////////////////////////////
// input side of the line doubler, samples every second clock, counts
// pixels and writes the active window of each line into one buffer page
////////////////////////////////////////////////////////////////////////////

`include "linemult_defs.svh"

module line_writer (
  input  logic                     VCLK_Tx_o,
  input  logic                     nVRST_Tx_o,
  input  video_pkg::vid_t          vid_i,
  input  logic                     pal_i,
  input  logic                     rd_run_i,
  output logic                     wr_en_o,
  output linemult_pkg::page_t      wr_page_o,
  output linemult_pkg::hcnt_t      wr_addr_o,
  output video_pkg::pixel_t        wr_pix_o,
  output logic                     line_done_o,
  output linemult_pkg::page_t      done_page_o,
  output linemult_pkg::line_info_t line_info_o,
  output logic                     overflow_o
);

  logic                phase_q;
  logic                nhs_q;
  linemult_pkg::hcnt_t hcnt_q;
  linemult_pkg::page_t page_q;

  logic                hs_fall;
  logic                in_win;
  linemult_pkg::hcnt_t cur_cnt;
  linemult_pkg::hcnt_t hstart;
  linemult_pkg::hcnt_t hstop;

  assign hstart = pal_i ? linemult_pkg::hcnt_t'(`HSTART_PAL) : linemult_pkg::hcnt_t'(`HSTART_NTSC);
  assign hstop  = pal_i ? linemult_pkg::hcnt_t'(`HSTOP_PAL) : linemult_pkg::hcnt_t'(`HSTOP_NTSC);

  // a line closes on the falling hsync edge seen between two samples
  assign hs_fall = phase_q & nhs_q & ~vid_i.sync.nhs;

  // count of the sample on the input now, held at the overflow mark
  always_comb begin
    if (hs_fall) begin
      cur_cnt = '0;
    end else if (hcnt_q == linemult_pkg::hcnt_t'(`LINE_MAX)) begin
      cur_cnt = hcnt_q;
    end else begin
      cur_cnt = hcnt_q + 1'b1;
    end
  end

  assign in_win     = (cur_cnt >= hstart) && (cur_cnt < hstop);
  assign overflow_o = (hcnt_q == linemult_pkg::hcnt_t'(`LINE_MAX));

  ////////////////////////////////////////////////////////////////////////////
  // sample phase, counters and strobes

  always_ff @(posedge VCLK_Tx_o or negedge nVRST_Tx_o) begin
    if (!nVRST_Tx_o) begin
      phase_q     <= 1'b1;
      nhs_q       <= 1'b0;
      hcnt_q      <= '0;
      page_q      <= '0;
      wr_en_o     <= 1'b0;
      line_done_o <= 1'b0;
    end else begin
      phase_q     <= ~phase_q;
      wr_en_o     <= phase_q & in_win;
      line_done_o <= hs_fall;
      if (phase_q) begin
        nhs_q  <= vid_i.sync.nhs;
        hcnt_q <= cur_cnt;
      end
      // pages stay at 0 until the reader is armed
      if (hs_fall) begin
        page_q <= rd_run_i ? page_q + 1'b1 : '0;
      end
    end
  end

  // data that travels with the strobes
  always_ff @(posedge VCLK_Tx_o) begin
    wr_page_o          <= page_q;
    wr_addr_o          <= cur_cnt - hstart;
    wr_pix_o           <= vid_i.pix;
    done_page_o        <= page_q;
    line_info_o.width  <= hcnt_q;
    line_info_o.vs_low <= ~vid_i.sync.nvs;
  end

endmodule

// ==== linebuf/line_buffer.sv ====
////////////////////////////////////////////////////////////////////////////
// four-page line memory with one write and one registered read port,
// plus a small table with width and vsync flag of each stored line
////////////////////////////////////////////////////////////////////////////

`include "linemult_defs.svh"

module line_buffer (
  input  logic                     VCLK_Tx_o,
  input  logic                     wr_en_i,
  input  linemult_pkg::page_t      wr_page_i,
  input  linemult_pkg::hcnt_t      wr_addr_i,
  input  video_pkg::pixel_t        wr_pix_i,
  input  logic                     info_we_i,
  input  linemult_pkg::page_t      info_page_i,
  input  linemult_pkg::line_info_t info_i,
  input  logic                     rd_en_i,
  input  linemult_pkg::page_t      rd_page_i,
  input  linemult_pkg::hcnt_t      rd_addr_i,
  output video_pkg::pixel_t        rd_pix_o,
  output linemult_pkg::line_info_t rd_info_o
);

  // a page holds the widest active window
  localparam int PAGE_DEPTH = 512;
  localparam int ADDR_W     = $clog2(PAGE_DEPTH);

  video_pkg::pixel_t        mem [0:`BUF_PAGES*PAGE_DEPTH-1];
  linemult_pkg::line_info_t info_tbl [0:`BUF_PAGES-1];

  always_ff @(posedge VCLK_Tx_o) begin
    if (wr_en_i) begin
      mem[{wr_page_i, wr_addr_i[ADDR_W-1:0]}] <= wr_pix_i;
    end
  end

  // read data keeps its value while no read is issued
  always_ff @(posedge VCLK_Tx_o) begin
    if (rd_en_i) begin
      rd_pix_o <= mem[{rd_page_i, rd_addr_i[ADDR_W-1:0]}];
    end
  end

  always_ff @(posedge VCLK_Tx_o) begin
    if (info_we_i) begin
      info_tbl[info_page_i] <= info_i;
    end
  end

  assign rd_info_o = info_tbl[rd_page_i];

endmodule

// ==== linebuf/line_reader.sv ====
////////////////////////////////////////////////////////////////////////////
// output side of the line doubler, plays every stored page twice at the
// full clock rate and regenerates hsync for each output line
////////////////////////////////////////////////////////////////////////////

`include "linemult_defs.svh"

module line_reader (
  input  logic                     VCLK_Tx_o,
  input  logic                     nVRST_Tx_o,
  input  linemult_pkg::cfg_t       cfg_i,
  input  logic                     line_done_i,
  input  linemult_pkg::page_t      done_page_i,
  input  logic                     overflow_i,
  input  linemult_pkg::line_info_t rd_info_i,
  input  video_pkg::pixel_t        rd_pix_i,
  output logic                     rd_run_o,
  output logic                     rd_en_o,
  output linemult_pkg::page_t      rd_page_o,
  output linemult_pkg::hcnt_t      rd_addr_o,
  output video_pkg::pixel_t        pix_o,
  output video_pkg::sync_t         sync_o,
  output logic                     second_o,
  output logic                     valid_o
);

  // arm_q lets the writer pages run and read_q produces output lines
  logic                arm_q;
  logic                read_q;
  logic                rep_q;
  linemult_pkg::hcnt_t h_q;
  linemult_pkg::page_t page_q;

  // stage aligned with the buffer read latency
  logic                valid_q;
  logic                win_q;
  logic                nhs_q;
  logic                nvs_q;
  logic                second_q;

  logic                in_win;
  logic                short_line;
  logic                stop;
  linemult_pkg::hcnt_t hstart;
  linemult_pkg::hcnt_t hstop;

  assign hstart = cfg_i.pal_mode ? linemult_pkg::hcnt_t'(`HSTART_PAL) :
                                   linemult_pkg::hcnt_t'(`HSTART_NTSC);
  assign hstop  = cfg_i.pal_mode ? linemult_pkg::hcnt_t'(`HSTOP_PAL) :
                                   linemult_pkg::hcnt_t'(`HSTOP_NTSC);

  assign in_win = (h_q >= hstart) && (h_q < hstop);

  // a stored line narrower than the window cannot be shown
  assign short_line = read_q && (rd_info_i.width < hstop);
  assign stop       = overflow_i || !cfg_i.lx2_en || short_line;

  assign rd_run_o  = arm_q;
  assign rd_en_o   = read_q && in_win;
  assign rd_page_o = page_q;
  assign rd_addr_o = h_q - hstart;

  ////////////////////////////////////////////////////////////////////////////
  // start/stop and line sequencing

  always_ff @(posedge VCLK_Tx_o or negedge nVRST_Tx_o) begin
    if (!nVRST_Tx_o) begin
      arm_q  <= 1'b0;
      read_q <= 1'b0;
      rep_q  <= 1'b0;
      h_q    <= '0;
      page_q <= '0;
    end else if (stop) begin
      arm_q  <= 1'b0;
      read_q <= 1'b0;
    end else if (!arm_q) begin
      arm_q <= line_done_i;
    end else if (!read_q) begin
      // wait until enough pages are filled ahead of us
      if (line_done_i && (done_page_i == linemult_pkg::page_t'(`START_PAGE))) begin
        read_q <= 1'b1;
        rep_q  <= 1'b0;
        h_q    <= '0;
        page_q <= '0;
      end
    end else if (h_q == rd_info_i.width) begin
      h_q   <= '0;
      rep_q <= ~rep_q;
      if (rep_q) begin
        page_q <= page_q + 1'b1;
      end
    end else begin
      h_q <= h_q + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // flags delayed by one clock to meet the buffer data

  always_ff @(posedge VCLK_Tx_o or negedge nVRST_Tx_o) begin
    if (!nVRST_Tx_o) begin
      valid_q  <= 1'b0;
      win_q    <= 1'b0;
      nhs_q    <= 1'b1;
      nvs_q    <= 1'b1;
      second_q <= 1'b0;
    end else begin
      valid_q  <= read_q;
      win_q    <= read_q && in_win;
      second_q <= rep_q;
      nhs_q    <= (h_q >= linemult_pkg::hcnt_t'(`HS_WIDTH));
      if (read_q) begin
        nvs_q <= ~rd_info_i.vs_low;
      end
    end
  end

  assign pix_o      = win_q ? rd_pix_i : '0;
  assign sync_o.nhs = valid_q ? nhs_q : 1'b1;
  assign sync_o.nvs = valid_q ? nvs_q : 1'b1;
  assign second_o   = second_q;
  assign valid_o    = valid_q;

endmodule

// ==== source/scanline_shade.sv ====
////////////////////////////////////////////////////////////////////////////
// darkens the second copy of each doubled line and registers the stream,
// passes the input through when doubling is off
////////////////////////////////////////////////////////////////////////////

`include "linemult_defs.svh"

module scanline_shade (
  input  logic               VCLK_Tx_o,
  input  logic               nVRST_Tx_o,
  input  linemult_pkg::cfg_t cfg_i,
  input  video_pkg::vid_t    vid_i,
  input  video_pkg::pixel_t  pix_i,
  input  video_pkg::sync_t   sync_i,
  input  logic               second_i,
  input  logic               valid_i,
  output video_pkg::vid_t    vid_o
);

  // channel times factor over 16
  function automatic logic [`COLOR_W-1:0] shade_chan(input logic [`COLOR_W-1:0] c,
                                                     input logic [4:0] f);
    logic [`COLOR_W+4:0] prod;
    prod = c * f;
    return prod[`COLOR_W+3:4];
  endfunction

  logic [4:0]        factor;
  logic              draw_sl;
  video_pkg::pixel_t sl_pix;
  video_pkg::vid_t   vid_q;

  assign factor  = 5'd16 - {1'b0, cfg_i.sl_str};
  assign draw_sl = cfg_i.sl_en && second_i;

  assign sl_pix.r = shade_chan(pix_i.r, factor);
  assign sl_pix.g = shade_chan(pix_i.g, factor);
  assign sl_pix.b = shade_chan(pix_i.b, factor);

  always_ff @(posedge VCLK_Tx_o or negedge nVRST_Tx_o) begin
    if (!nVRST_Tx_o) begin
      vid_q.sync <= '1;
      vid_q.pix  <= '0;
    end else if (!cfg_i.lx2_en) begin
      // bypass
      vid_q <= vid_i;
    end else if (valid_i) begin
      vid_q.sync <= sync_i;
      vid_q.pix  <= draw_sl ? sl_pix : pix_i;
    end else begin
      vid_q.sync <= '1;
      vid_q.pix  <= '0;
    end
  end

  assign vid_o = vid_q;

endmodule

// ==== source/linemult_top.sv ====
////////////////////////////////////////////////////////////////////////////
// line doubler top level, connects writer, line buffer, reader and shader
////////////////////////////////////////////////////////////////////////////

module linemult_top (
  input  logic                VCLK_Tx_o,
  input  logic                nVRST_Tx_o,
  input  video_pkg::vid_t     vid_i,
  input  linemult_pkg::cfg_t  cfg_i,
  output video_pkg::vid_t     vid_o
);

  // writer side
  logic                     wr_en;
  linemult_pkg::page_t      wr_page;
  linemult_pkg::hcnt_t      wr_addr;
  video_pkg::pixel_t        wr_pix;
  logic                     line_done;
  linemult_pkg::page_t      done_page;
  linemult_pkg::line_info_t wr_info;
  logic                     overflow;

  // reader side
  logic                     rd_run;
  logic                     rd_en;
  linemult_pkg::page_t      rd_page;
  linemult_pkg::hcnt_t      rd_addr;
  video_pkg::pixel_t        buf_pix;
  linemult_pkg::line_info_t rd_info;
  video_pkg::pixel_t        rd_pix;
  video_pkg::sync_t         rd_sync;
  logic                     rd_second;
  logic                     rd_valid;

  line_writer i_writer (
    .VCLK_Tx_o   (VCLK_Tx_o),
    .nVRST_Tx_o  (nVRST_Tx_o),
    .vid_i       (vid_i),
    .pal_i       (cfg_i.pal_mode),
    .rd_run_i    (rd_run),
    .wr_en_o     (wr_en),
    .wr_page_o   (wr_page),
    .wr_addr_o   (wr_addr),
    .wr_pix_o    (wr_pix),
    .line_done_o (line_done),
    .done_page_o (done_page),
    .line_info_o (wr_info),
    .overflow_o  (overflow)
  );

  line_buffer i_buffer (
    .VCLK_Tx_o   (VCLK_Tx_o),
    .wr_en_i     (wr_en),
    .wr_page_i   (wr_page),
    .wr_addr_i   (wr_addr),
    .wr_pix_i    (wr_pix),
    .info_we_i   (line_done),
    .info_page_i (done_page),
    .info_i      (wr_info),
    .rd_en_i     (rd_en),
    .rd_page_i   (rd_page),
    .rd_addr_i   (rd_addr),
    .rd_pix_o    (buf_pix),
    .rd_info_o   (rd_info)
  );

  line_reader i_reader (
    .VCLK_Tx_o   (VCLK_Tx_o),
    .nVRST_Tx_o  (nVRST_Tx_o),
    .cfg_i       (cfg_i),
    .line_done_i (line_done),
    .done_page_i (done_page),
    .overflow_i  (overflow),
    .rd_info_i   (rd_info),
    .rd_pix_i    (buf_pix),
    .rd_run_o    (rd_run),
    .rd_en_o     (rd_en),
    .rd_page_o   (rd_page),
    .rd_addr_o   (rd_addr),
    .pix_o       (rd_pix),
    .sync_o      (rd_sync),
    .second_o    (rd_second),
    .valid_o     (rd_valid)
  );

  scanline_shade i_shade (
    .VCLK_Tx_o  (VCLK_Tx_o),
    .nVRST_Tx_o (nVRST_Tx_o),
    .cfg_i      (cfg_i),
    .vid_i      (vid_i),
    .pix_i      (rd_pix),
    .sync_i     (rd_sync),
    .second_i   (rd_second),
    .valid_i    (rd_valid),
    .vid_o      (vid_o)
  );

endmodule

// ==== test/linemult_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for the line doubler, reads test cases from the trace file,
// drives an RGB stream into linemult_top and checks the doubled output
////////////////////////////////////////////////////////////////////////////

`include "linemult_defs.svh"

module linemult_tb;

  localparam int VS_LINES     = 8;
  localparam int HS_LOW       = 32;
  localparam int TIMEOUT_CLKS = 20000;
  localparam video_pkg::vid_t IDLE_VID = {2'b11, {(3*`COLOR_W){1'b0}}};

  logic               VCLK_Tx_o;
  logic               nVRST_Tx_o;
  video_pkg::vid_t    vid_i;
  linemult_pkg::cfg_t cfg_i;
  video_pkg::vid_t    vid_o;

  bit                 drive_done;
  bit                 long_started;
  logic [31:0]        lfsr_q;

  linemult_top i_dut (
    .VCLK_Tx_o  (VCLK_Tx_o),
    .nVRST_Tx_o (nVRST_Tx_o),
    .vid_i      (vid_i),
    .cfg_i      (cfg_i),
    .vid_o      (vid_o)
  );

  initial begin
    VCLK_Tx_o = 1'b0;
    forever #20 VCLK_Tx_o = ~VCLK_Tx_o;
  end

  ////////////////////////////////////////////////////////////////////////////
  // failure reporting and compare tasks

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "stopped at the first failing check");
  endtask

  task automatic check_vid(input video_pkg::vid_t got, input video_pkg::vid_t exp,
                           input string what);
    if (got !== exp) begin
      abort_run($sformatf("error at time %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_pixel(input video_pkg::pixel_t got, input video_pkg::pixel_t exp,
                             input string what);
    if (got !== exp) begin
      abort_run($sformatf("error at time %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_sync(input video_pkg::sync_t got, input video_pkg::sync_t exp,
                            input string what);
    if (got !== exp) begin
      abort_run($sformatf("error at time %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_count(input linemult_pkg::hcnt_t got, input linemult_pkg::hcnt_t exp,
                             input string what);
    if (got !== exp) begin
      abort_run($sformatf("error at time %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic random_pixel(output video_pkg::pixel_t p);
    logic [3*`COLOR_W-1:0] bits;
    int i;
    for (i = 0; i < 3 * `COLOR_W; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      bits[i] = lfsr_q[0];
    end
    p = bits;
  endtask

  // red always has its top bit set, so window pixels are never zero
  function automatic video_pkg::pixel_t line_pixel(input video_pkg::pixel_t base,
                                                  input int line_idx, input int c);
    video_pkg::pixel_t p;
    p.r = base.r;
    p.r[`COLOR_W-1] = 1'b1;
    p.g = base.g ^ line_idx[`COLOR_W-1:0];
    p.b = base.b ^ c[`COLOR_W-1:0];
    return p;
  endfunction

  // scale each channel by f/16
  function automatic video_pkg::pixel_t dim_pixel(input video_pkg::pixel_t p, input int f);
    video_pkg::pixel_t q;
    int tmp;
    tmp = (p.r * f) / 16;
    q.r = tmp[`COLOR_W-1:0];
    tmp = (p.g * f) / 16;
    q.g = tmp[`COLOR_W-1:0];
    tmp = (p.b * f) / 16;
    q.b = tmp[`COLOR_W-1:0];
    return q;
  endfunction

  task automatic reset_dut(input linemult_pkg::cfg_t cfg);
    @(posedge VCLK_Tx_o);
    nVRST_Tx_o <= 1'b0;
    cfg_i      <= cfg;
    vid_i      <= IDLE_VID;
    repeat (2) @(posedge VCLK_Tx_o);
    nVRST_Tx_o <= 1'b1;
  endtask

  // one sample every second clock, first one on the release edge
  task automatic drive_line(input int line_idx, input int nsamples,
                            input video_pkg::pixel_t base);
    video_pkg::vid_t s;
    int c;
    for (c = 0; c < nsamples; c++) begin
      s.sync.nhs = (c >= HS_LOW);
      s.sync.nvs = (line_idx >= VS_LINES);
      s.pix      = line_pixel(base, line_idx, c);
      vid_i <= s;
      repeat (2) @(posedge VCLK_Tx_o);
    end
  endtask

  task automatic drive_stream(input int nlines, input int width, input int long_w,
                              input video_pkg::pixel_t base);
    int l;
    for (l = 0; l < nlines; l++) begin
      drive_line(l, width, base);
    end
    if (long_w != 0) begin
      long_started = 1'b1;
      drive_line(nlines, long_w, base);
    end
    vid_i <= IDLE_VID;
    drive_done = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // output checkers, all sampling on the falling clock edge

  task automatic wait_hs_fall();
    logic prev;
    int n;
    prev = vid_o.sync.nhs;
    @(negedge VCLK_Tx_o);
    n = 0;
    while (!(prev && !vid_o.sync.nhs)) begin
      if (n == TIMEOUT_CLKS) begin
        abort_run("timeout: no falling edge on the output hsync");
      end
      prev = vid_o.sync.nhs;
      @(negedge VCLK_Tx_o);
      n++;
    end
  endtask

  task automatic check_bypass();
    video_pkg::vid_t prev;
    int n;
    n = 0;
    @(negedge VCLK_Tx_o);
    prev = vid_i;
    while (!drive_done) begin
      if (n == TIMEOUT_CLKS) begin
        abort_run("timeout: the bypass stream did not end");
      end
      @(negedge VCLK_Tx_o);
      check_vid(vid_o, prev, "bypass output");
      prev = vid_i;
      n++;
    end
  endtask

  // line 0 is cut by reset, the lines after source nlines-4 are cut by the
  // overflow that follows once the input goes idle
  task automatic check_doubled(input linemult_pkg::cfg_t cfg, input int nlines,
                               input int width, input video_pkg::pixel_t base,
                               input int f_first, input int f_second, input int nz_exp);
    int hstart;
    int hstop;
    int j;
    int h;
    int src;
    linemult_pkg::hcnt_t nz;
    linemult_pkg::hcnt_t nz_ref;
    video_pkg::pixel_t exp_pix;
    video_pkg::sync_t exp_sync;
    hstart = cfg.pal_mode ? `HSTART_PAL : `HSTART_NTSC;
    hstop  = cfg.pal_mode ? `HSTOP_PAL : `HSTOP_NTSC;
    nz_ref = nz_exp[`HCNT_W-1:0];
    for (j = 0; j < 2 * (nlines - 4); j++) begin
      src = 1 + j / 2;
      wait_hs_fall();
      nz = '0;
      for (h = 0; h < width; h++) begin
        if (h > 0) begin
          @(negedge VCLK_Tx_o);
        end
        exp_sync.nhs = (h >= `HS_WIDTH);
        // the vsync flag of a line is taken at the sample that closes it
        exp_sync.nvs = (src + 1 >= VS_LINES);
        exp_pix = '0;
        if (h >= hstart && h < hstop) begin
          exp_pix = dim_pixel(line_pixel(base, src, h), (j % 2) ? f_second : f_first);
        end
        check_sync(vid_o.sync, exp_sync, $sformatf("sync of output line %0d pixel %0d", j, h));
        check_pixel(vid_o.pix, exp_pix, $sformatf("output line %0d pixel %0d", j, h));
        if (vid_o.pix != '0) begin
          nz++;
        end
      end
      if (nz_exp != 0) begin
        check_count(nz, nz_ref, $sformatf("nonzero pixels of output line %0d", j));
      end
    end
  endtask

  task automatic check_overflow(input int width);
    int n;
    int falls;
    logic prev;
    n = 0;
    while (!long_started) begin
      if (n == TIMEOUT_CLKS) begin
        abort_run("timeout: the overlong input line never started");
      end
      @(negedge VCLK_Tx_o);
      n++;
    end
    // two input line times for the output to stop
    falls = 0;
    prev  = vid_o.sync.nhs;
    for (n = 0; n < 4 * width; n++) begin
      @(negedge VCLK_Tx_o);
      if (prev && !vid_o.sync.nhs) begin
        falls++;
      end
      prev = vid_o.sync.nhs;
    end
    if (falls == 0) begin
      abort_run("the reader was not running when the overlong line began");
    end
    for (n = 0; n < width; n++) begin
      @(negedge VCLK_Tx_o);
      check_vid(vid_o, IDLE_VID, "output after overflow");
    end
  endtask

  task automatic run_case(input int cfg_v, input int nlines, input int width,
                          input int long_w, input int base_v, input int f_first,
                          input int f_second, input int nz_exp);
    linemult_pkg::cfg_t cfg;
    video_pkg::pixel_t base;
    cfg  = cfg_v[6:0];
    base = base_v[3*`COLOR_W-1:0];
    if (base == '0) begin
      random_pixel(base);
    end
    drive_done   = 1'b0;
    long_started = 1'b0;
    reset_dut(cfg);
    fork
      drive_stream(nlines, width, long_w, base);
      begin
        if (!cfg.lx2_en) begin
          check_bypass();
        end else if (long_w != 0) begin
          check_overflow(width);
        end else begin
          check_doubled(cfg, nlines, width, base, f_first, f_second, nz_exp);
        end
      end
    join
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    int fd;
    int ncases;
    string line;
    int cfg_v;
    int nlines;
    int width;
    int long_w;
    int base_v;
    int f_first;
    int f_second;
    int nz_exp;
    nVRST_Tx_o   = 1'b0;
    cfg_i        = '0;
    vid_i        = IDLE_VID;
    drive_done   = 1'b0;
    long_started = 1'b0;
    lfsr_q       = 32'h9e6d;
    ncases       = 0;
    fd = $fopen("test/linemult_trace.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open the trace file test/linemult_trace.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != "#") begin
        if ($sscanf(line, "%h %h %h %h %h %h %h %h", cfg_v, nlines, width, long_w,
                    base_v, f_first, f_second, nz_exp) != 8) begin
          abort_run("malformed line in the trace file");
        end
        run_case(cfg_v, nlines, width, long_w, base_v, f_first, f_second, nz_exp);
        ncases++;
      end
    end
    $fclose(fd);
    if (ncases == 0) begin
      abort_run("the trace file holds no test case");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

// ==== test/linemult_trace.txt ====
# line doubler test cases, one per line, all fields hex
# cfg nlines width long_width base f_first f_second nonzero
# cfg packs lx2_en pal_mode sl_en sl_str[3:0], base 000000 asks for a random base pixel
# f_first and f_second scale the channels of the two copies in steps of 1/16
# long_width adds one overlong input line at the end, 0 for none
# nonzero is the count of nonzero pixels per output line, 0 skips that check
# bypass
00 06 2bc 000 1a2b3c 10 10 000
# doubling with the NTSC window
40 0e 2bc 000 000000 10 10 1e0
# PAL window
60 0c 2bc 000 0d4e1f 10 10 200
# scanlines at strength 8
58 0c 2bc 000 000000 10 08 1e0
# overlong line drops the output
40 08 2bc 5dc 13579b 10 10 000

// ==== src.f ====
+incdir+common
common/video_pkg.sv
common/linemult_pkg.sv
linebuf/line_writer.sv
linebuf/line_buffer.sv
linebuf/line_reader.sv
source/scanline_shade.sv
source/linemult_top.sv
test/linemult_tb.sv
